//--- filelist.f
verilog/lru_pkg.sv
verilog/lru_step_if.sv
verilog/lru_ctrl.sv
verilog/lru_counter_mem.sv
verilog/lru_update.sv
verilog/lru_unit.sv
verif/lru_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LRU unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module lru_unit_tb \
    -Mdir obj_dir \
    -f filelist.f

./obj_dir/Vlru_unit_tb > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0

//--- verif/lru_unit_tb.sv
`timescale 1ns/1ps

module lru_unit_tb;

    localparam int RESET_CYCLES = 8;
    localparam int NUM_REQ      = 8 + 10 + 6 + 6 + 200; // requests over all five tests
    localparam int MARGIN       = 300;                  // room for gaps and back-pressure
    localparam int RESP_LIMIT   = 20;                   // cycles a request may stay open

    logic              clk;
    logic              reset;
    logic              val_i;
    lru_pkg::set_t     set_index_i;
    logic              h_m_i;
    lru_pkg::way_t     cache_hit_index_i;
    logic              rdy_i;
    logic              rdy_o;
    logic              val_o;
    lru_pkg::way_t     wayindex_o;
    lru_pkg::ctr_row_t counters_o;

    lru_pkg::ctr_row_t model [lru_pkg::NUM_SETS]; // expected ages of every set
    lru_pkg::way_t     exp_way_q [$];
    lru_pkg::ctr_row_t exp_row_q [$];

    int cyc = 0;         // rising edges since time zero
    int acc_edge = 0;    // edge that accepted the open request
    bit in_flight = 0;
    bit val_seen = 0;    // val_o at the previous sample
    bit hold_on = 0;     // previous sample had val_o high and rdy_i low
    lru_pkg::way_t     hold_way;
    lru_pkg::ctr_row_t hold_row;
    lru_pkg::way_t     last_way; // last response taken
    lru_pkg::ctr_row_t last_row;
    int errors = 0;
    int req_count = 0;
    int resp_count = 0;
    int test_errors = 0; // error count when the current test started
    bit tripped = 0;

    lru_unit dut0 (
        .clk               (clk),
        .reset             (reset),
        .val_i             (val_i),
        .set_index_i       (set_index_i),
        .h_m_i             (h_m_i),
        .cache_hit_index_i (cache_hit_index_i),
        .rdy_i             (rdy_i),
        .rdy_o             (rdy_o),
        .val_o             (val_o),
        .wayindex_o        (wayindex_o),
        .counters_o        (counters_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cyc = cyc + 1;
    end

    // age rule for hit and miss where the returned way is the one that ends at the top age
    function automatic lru_pkg::ctr_row_t ref_update(input lru_pkg::ctr_row_t row, input logic hit,
                                                     input lru_pkg::way_t hit_way,
                                                     output lru_pkg::way_t sel_way);
        lru_pkg::ctr_row_t res;
        lru_pkg::ctr_t     pivot;
        int                w;
        res = row;
        sel_way = hit_way;
        pivot = row[hit_way];
        for (w = 0; w < lru_pkg::NUM_WAYS; w++)
        begin
            if (hit)
            begin
                if (row[w] > pivot)
                    res[w] = row[w] - lru_pkg::ctr_t'(1); // more recent than the hit way so it ages
            end
            else if (row[w] == lru_pkg::ctr_t'(0))
            begin
                res[w] = lru_pkg::CTR_MRU; // the victim is refilled
                sel_way = lru_pkg::way_t'(w);
            end
            else
            begin
                res[w] = row[w] - lru_pkg::ctr_t'(1);
            end
        end
        if (hit)
            res[hit_way] = lru_pkg::CTR_MRU;
        return res;
    endfunction

    // samples in mid cycle so a handshake seen here completes on the next rising edge
    always @(negedge clk)
    begin
        lru_pkg::way_t     e_way;
        lru_pkg::ctr_row_t e_row;
        if (!reset)
        begin
            if (in_flight)
                assert (rdy_o == 1'b0) else
                begin
                    $display("mismatch rdy_o: expected %h, got %h", 1'b0, rdy_o);
                    errors++;
                end
            if (hold_on)
            begin
                // the sink stalled so the offer must not move
                assert (val_o == 1'b1) else
                begin
                    $display("mismatch val_o: expected %h, got %h", 1'b1, val_o);
                    errors++;
                end
                assert (wayindex_o == hold_way) else
                begin
                    $display("mismatch wayindex_o: expected %h, got %h", hold_way, wayindex_o);
                    errors++;
                end
                assert (counters_o == hold_row) else
                begin
                    $display("mismatch counters_o: expected %h, got %h", hold_row, counters_o);
                    errors++;
                end
            end
            if (val_o && !val_seen)
                assert (cyc - acc_edge == 3) else // val_o rises right after edge E+3
                begin
                    $display("mismatch val_o latency: expected %h, got %h", 3, cyc - acc_edge);
                    errors++;
                end
            val_seen = val_o;
            hold_on  = val_o && !rdy_i;
            hold_way = wayindex_o;
            hold_row = counters_o;
            if (val_o && rdy_i)
            begin
                if (exp_row_q.size() == 0)
                begin
                    $display("response offered while no request was outstanding");
                    errors++;
                end
                else
                begin
                    e_way = exp_way_q.pop_front();
                    e_row = exp_row_q.pop_front();
                    assert (wayindex_o == e_way) else
                    begin
                        $display("mismatch wayindex_o: expected %h, got %h", e_way, wayindex_o);
                        errors++;
                    end
                    assert (counters_o == e_row) else
                    begin
                        $display("mismatch counters_o: expected %h, got %h", e_row, counters_o);
                        errors++;
                    end
                end
                last_way  = wayindex_o;
                last_row  = counters_o;
                resp_count++;
                in_flight = 0;
            end
            if (val_i && rdy_o)
            begin
                e_row = ref_update(model[set_index_i], h_m_i, cache_hit_index_i, e_way);
                model[set_index_i] = e_row; // write-back is modelled at acceptance
                exp_way_q.push_back(e_way);
                exp_row_q.push_back(e_row);
                acc_edge  = cyc + 1;
                in_flight = 1;
                req_count++;
            end
        end
    end

    // runs one full request with gap idle cycles first and bp stalled edges once val_o is up
    task automatic run_request(input lru_pkg::set_t s, input logic h, input lru_pkg::way_t w,
                               input int gap, input int bp, input bit hold_val);
        if (gap > 0)
            val_i = 1'b0;
        repeat (gap)
        begin
            @(posedge clk);
            #2;
        end
        rdy_i             = (bp == 0);
        val_i             = 1'b1;
        set_index_i       = s;
        h_m_i             = h;
        cache_hit_index_i = w;
        @(negedge clk);
        while (!rdy_o)
            @(negedge clk);
        @(posedge clk);
        #2;
        val_i             = hold_val; // a held val_i must not sneak in a second request
        set_index_i       = lru_pkg::set_t'($urandom);
        h_m_i             = 1'($urandom);
        cache_hit_index_i = lru_pkg::way_t'($urandom);
        @(negedge clk);
        while (!val_o)
            @(negedge clk);
        if (bp > 0)
        begin
            repeat (bp) @(posedge clk);
            #2;
            rdy_i = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic report_and_finish();
        if (req_count != resp_count)
        begin
            $display("%0d accepted requests never got a response", req_count - resp_count);
            errors++;
        end
        $display("summary: %0d requests, %0d responses, %0d errors", req_count, resp_count, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    endtask

    initial
    begin
        int                seed_ret;
        int                i;
        int                prev_edge;
        lru_pkg::way_t     hit_ways [10];
        lru_pkg::ctr_row_t fresh_row;
        clk               = 1'b0;
        reset             = 1'b1;
        val_i             = 1'b0;
        set_index_i       = '0;
        h_m_i             = 1'b0;
        cache_hit_index_i = '0;
        rdy_i             = 1'b1;
        seed_ret          = $urandom(32'haa0e);
        hit_ways          = '{0, 2, 1, 3, 3, 0, 1, 2, 0, 1};
        fresh_row         = {2'd3, 2'd0, 2'd1, 2'd2}; // ages of ways 3 down to 0 after one miss
        for (i = 0; i < lru_pkg::NUM_SETS; i++)
            model[i] = lru_pkg::CTR_RESET_ROW;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        assert (rdy_o == 1'b1 && val_o == 1'b0 && wayindex_o == '0 && counters_o == '0) else
        begin
            $display("mismatch reset outputs: expected %h, got %h", 12'h800,
                     {rdy_o, val_o, wayindex_o, counters_o});
            errors++;
        end
        @(posedge clk);
        #2;
        for (i = 0; i < lru_pkg::NUM_SETS; i++)
        begin
            run_request(lru_pkg::set_t'(i), 1'b0, '0, 0, 0, 1'b0);
            assert (last_way == lru_pkg::way_t'(3)) else
            begin
                $display("mismatch wayindex_o: expected %h, got %h", 2'd3, last_way);
                errors++;
            end
            assert (last_row == fresh_row) else
            begin
                $display("mismatch counters_o: expected %h, got %h", fresh_row, last_row);
                errors++;
            end
        end
        end_test("reset_state");

        for (i = 0; i < 10; i++)
            run_request(lru_pkg::set_t'(5), 1'b1, hit_ways[i], 1, 0, 1'b0);
        end_test("hit_rule");

        prev_edge = 0;
        for (i = 0; i < 6; i++)
        begin
            run_request(lru_pkg::set_t'(i), 1'($urandom), lru_pkg::way_t'($urandom), 0, 0, 1'b0);
            if (i > 0)
                assert (acc_edge - prev_edge == 5) else // back to back with rdy_i held high
                begin
                    $display("mismatch accept spacing: expected %h, got %h", 5,
                             acc_edge - prev_edge);
                    errors++;
                end
            prev_edge = acc_edge;
        end
        end_test("latency");

        for (i = 0; i < 6; i++)
            run_request(lru_pkg::set_t'($urandom), 1'($urandom), lru_pkg::way_t'($urandom),
                        0, 1 + $urandom % 12, 1'b1);
        end_test("back_pressure");

        for (i = 0; i < 200; i++)
            run_request(lru_pkg::set_t'($urandom), 1'($urandom), lru_pkg::way_t'($urandom),
                        $urandom % 3, $urandom % 4, 1'b0);
        end_test("random_mix");

        report_and_finish();
    end

    // guards the whole run and each open request
    initial
    begin : watchdog
        int limit;
        limit = RESET_CYCLES + NUM_REQ * 10 + MARGIN;
        while (!tripped)
        begin
            @(posedge clk);
            if (cyc > limit)
            begin
                $display("timeout: the run did not finish within %0d cycles", limit);
                tripped = 1;
            end
            else if (in_flight && cyc - acc_edge > RESP_LIMIT)
            begin
                $display("timeout: request accepted at cycle %0d got no response within %0d cycles",
                         acc_edge, RESP_LIMIT);
                tripped = 1;
            end
        end
        errors++;
        report_and_finish();
    end

endmodule

//--- verilog/lru_counter_mem.sv
`timescale 1ns/1ps

module lru_counter_mem (
    input  logic     clk,
    input  logic     reset,
    lru_step_if.mem  step
);

    // one row of age counters per set
    lru_pkg::ctr_row_t rows [lru_pkg::NUM_SETS];

    lru_pkg::ctr_row_t rd_q; // row fetched by the last read step

    // reset puts every set back to the same starting order
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < lru_pkg::NUM_SETS; s++)
            begin
                rows[s] <= lru_pkg::CTR_RESET_ROW;
            end
        end
        else if (step.wr_en)
        begin
            rows[step.set_idx] <= step.new_row; // write-back of the updated ages
        end
    end

    // the read is registered, so the row appears one edge after rd_en
    // and holds through the calculate step
    always_ff @(posedge clk)
    begin
        if (step.rd_en)
        begin
            rd_q <= rows[step.set_idx];
        end
    end

    assign step.cur_row = rd_q;

endmodule

//--- verilog/lru_ctrl.sv
`timescale 1ns/1ps

module lru_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              val_i,
    input  lru_pkg::set_t     set_index_i,
    input  logic              h_m_i,
    input  lru_pkg::way_t     cache_hit_index_i,
    input  logic              rdy_i,
    output logic              rdy_o,
    output logic              val_o,
    lru_step_if.ctrl          step
);

    lru_pkg::lru_state_t state_q;
    lru_pkg::lru_state_t state_d;

    logic req_go;  // request handshake completes on this edge
    logic resp_go; // response handshake completes on this edge

    // request fields, kept stable while the steps run
    lru_pkg::set_t set_q;
    logic          hit_q;
    lru_pkg::way_t hit_way_q;

    assign req_go  = val_i && rdy_o;
    assign resp_go = val_o && rdy_i;

    // each step takes exactly one cycle, only WAIT and DONE hold for a handshake
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            lru_pkg::WAIT:
            begin
                if (req_go)
                begin
                    state_d = lru_pkg::READ;
                end
            end
            lru_pkg::READ:  state_d = lru_pkg::CALC;
            lru_pkg::CALC:  state_d = lru_pkg::WRITE;
            lru_pkg::WRITE: state_d = lru_pkg::DONE;
            lru_pkg::DONE:
            begin
                if (resp_go)
                begin
                    state_d = lru_pkg::WAIT; // sink took the answer, open for the next one
                end
            end
            default: state_d = lru_pkg::WAIT;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state_q <= lru_pkg::WAIT;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // sampled only on acceptance, so the fields may change freely afterwards
    always_ff @(posedge clk)
    begin
        if (req_go)
        begin
            set_q     <= set_index_i;
            hit_q     <= h_m_i;
            hit_way_q <= cache_hit_index_i;
        end
    end

    assign step.set_idx = set_q;
    assign step.hit     = hit_q;
    assign step.hit_way = hit_way_q;

    //  state   rdy_o val_o rd_en calc_en wr_en
    //  WAIT      1     0     0      0      0
    //  READ      0     0     1      0      0
    //  CALC      0     0     0      1      0
    //  WRITE     0     0     0      0      1
    //  DONE      0     1     0      0      0
    always_comb
    begin
        rdy_o        = 1'b0;
        val_o        = 1'b0;
        step.rd_en   = 1'b0;
        step.calc_en = 1'b0;
        step.wr_en   = 1'b0;
        case (state_q)
            lru_pkg::WAIT:  rdy_o        = 1'b1;
            lru_pkg::READ:  step.rd_en   = 1'b1;
            lru_pkg::CALC:  step.calc_en = 1'b1;
            lru_pkg::WRITE: step.wr_en   = 1'b1;
            lru_pkg::DONE:  val_o        = 1'b1;
            default:        rdy_o        = 1'b0; // unused encodings stay silent
        endcase
    end

endmodule

//--- verilog/lru_pkg.sv
package lru_pkg;

    // cache geometry, a 4-way set associative array with 8 sets
    localparam int NUM_WAYS = 4;
    localparam int NUM_SETS = 8;

    localparam int WAY_W = $clog2(NUM_WAYS); // bits needed to name one way
    localparam int SET_W = $clog2(NUM_SETS); // bits needed to name one set
    localparam int CTR_W = 2;                // one age counter per way

    typedef logic [WAY_W-1:0] way_t;
    typedef logic [SET_W-1:0] set_t;
    typedef logic [CTR_W-1:0] ctr_t;

    // one row holds the ages of all ways of a set, way 0 sits in the low bits
    typedef ctr_t [NUM_WAYS-1:0] ctr_row_t;

    // the age a way receives when it is touched, the highest counter value
    localparam ctr_t CTR_MRU = ctr_t'(3);

    // the starting order after reset makes way 3 the first victim
    localparam ctr_row_t CTR_RESET_ROW = {
        ctr_t'(0), // way 3
        ctr_t'(1), // way 2
        ctr_t'(2), // way 1
        ctr_t'(3)  // way 0
    };

    // controller steps, one request walks through them in this order
    typedef enum logic [2:0] {
        WAIT,  // idle, ready for a request
        READ,  // counter row is fetched from the memory
        CALC,  // new ages and the chosen way are computed
        WRITE, // updated row goes back into the memory
        DONE   // response is offered until the sink takes it
    } lru_state_t;

endpackage

//--- verilog/lru_step_if.sv
`timescale 1ns/1ps

interface lru_step_if;

    // captured request, held by the controller for the whole sequence
    lru_pkg::set_t set_idx;
    logic          hit;
    lru_pkg::way_t hit_way;

    logic rd_en;   // fetch the addressed row
    logic calc_en; // latch the updated row and way
    logic wr_en;   // store the updated row

    lru_pkg::ctr_row_t cur_row; // row as it was before this request
    lru_pkg::ctr_row_t new_row; // row after the age update

    // the controller steers, the memory and the update block follow
    modport ctrl (
        output set_idx, hit, hit_way, rd_en, calc_en, wr_en
    );

    modport mem (
        input  set_idx, rd_en, wr_en, new_row,
        output cur_row
    );

    modport upd (
        input  hit, hit_way, calc_en, cur_row,
        output new_row
    );

endinterface

//--- verilog/lru_unit.sv
`timescale 1ns/1ps

module lru_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               val_i,
    input  lru_pkg::set_t      set_index_i,
    input  logic               h_m_i,
    input  lru_pkg::way_t      cache_hit_index_i,
    input  logic               rdy_i,
    output logic               rdy_o,
    output logic               val_o,
    output lru_pkg::way_t      wayindex_o,
    output lru_pkg::ctr_row_t  counters_o
);

    // carries the captured request, the step strobes and both rows
    lru_step_if step_bus ();

    // sequences one request through read, calculate and write
    lru_ctrl ctrl0 (
        .clk               (clk),
        .reset             (reset),
        .val_i             (val_i),
        .set_index_i       (set_index_i),
        .h_m_i             (h_m_i),
        .cache_hit_index_i (cache_hit_index_i),
        .rdy_i             (rdy_i),
        .rdy_o             (rdy_o),
        .val_o             (val_o),
        .step              (step_bus.ctrl)
    );

    // age counters for every set
    lru_counter_mem mem0 (
        .clk   (clk),
        .reset (reset),
        .step  (step_bus.mem)
    );

    // the response comes straight from the update block's result register
    lru_update upd0 (
        .clk        (clk),
        .reset      (reset),
        .step       (step_bus.upd),
        .wayindex_o (wayindex_o),
        .counters_o (counters_o)
    );

endmodule

//--- verilog/lru_update.sv
`timescale 1ns/1ps

module lru_update (
    input  logic               clk,
    input  logic               reset,
    lru_step_if.upd            step,
    output lru_pkg::way_t      wayindex_o,
    output lru_pkg::ctr_row_t  counters_o
);

    lru_pkg::ctr_t hit_age; // age of the way that was hit

    // per-way choice, MRU wins over decrement, neither means keep
    logic [lru_pkg::NUM_WAYS-1:0] sel_mru;
    logic [lru_pkg::NUM_WAYS-1:0] sel_dec;

    lru_pkg::ctr_row_t upd_row; // ages after this request
    lru_pkg::way_t     upd_way; // the way that became most recent

    lru_pkg::ctr_row_t row_q;
    lru_pkg::way_t     way_q;

    assign hit_age = step.cur_row[step.hit_way];

    always_comb
    begin
        for (int i = 0; i < lru_pkg::NUM_WAYS; i++)
        begin
            if (step.hit)
            begin
                // only ways younger than the hit way move down one place
                sel_mru[i] = (lru_pkg::way_t'(i) == step.hit_way);
                sel_dec[i] = step.cur_row[i] > hit_age;
            end
            else
            begin
                // on a miss the oldest way is replaced and all others age
                sel_mru[i] = (step.cur_row[i] == '0);
                sel_dec[i] = !sel_mru[i];
            end
        end
    end

    always_comb
    begin
        upd_row = step.cur_row; // ways with no selection keep their age
        upd_way = '0;
        for (int i = 0; i < lru_pkg::NUM_WAYS; i++)
        begin
            if (sel_mru[i])
            begin
                upd_row[i] = lru_pkg::CTR_MRU;
                upd_way    = lru_pkg::way_t'(i); // one-hot select turned into an index
            end
            else if (sel_dec[i])
            begin
                upd_row[i] = step.cur_row[i] - 1'b1;
            end
        end
    end

    // the result is held from the calculate step until the next request
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            row_q <= '0;
            way_q <= '0;
        end
        else if (step.calc_en)
        begin
            row_q <= upd_row;
            way_q <= upd_way;
        end
    end

    assign step.new_row = row_q; // same value is written back and returned
    assign counters_o   = row_q;
    assign wayindex_o   = way_q;

endmodule
